//--- tw_defs.svh
`ifndef TW_DEFS_SVH
`define TW_DEFS_SVH

// Word layout
`define TW_HALF_W    64

// Table geometry
`define TW_ENTRIES   4
`define TW_GROUPS_1  4
`define TW_REPEAT_1  16
`define TW_IDX_W     4

// Flow control
`define TW_CREDITS   4
`define TW_CREDIT_W  3

`endif

//--- ntt_ctrl_pkg.sv
`default_nettype none

package ntt_ctrl_pkg;

   // Transform stage served by the twiddle source
   typedef enum logic [1:0] {
      STAGE_IDLE = 2'd0,
      STAGE_1    = 2'd1,
      STAGE_2    = 2'd2
   } stage_e;

   // Butterfly operation, encodings shared with the datapath controller
   typedef enum logic [3:0] {
      OP_NONE = 4'd0,
      OP_NTT  = 4'd4,
      OP_INTT = 4'd6
   } op_e;

endpackage

`default_nettype wire

//--- tw_data_pkg.sv
`default_nettype none

`include "tw_defs.svh"

package tw_data_pkg;

   // Two residues, one per modulus
   typedef struct packed {
      logic [`TW_HALF_W-1:0] hi;
      logic [`TW_HALF_W-1:0] lo;
   } tw_word_t;

   // Output beat toward the butterfly datapath
   typedef struct packed {
      logic     valid;
      tw_word_t word;
      tw_word_t const_word;   // Stage constant
   } tw_beat_t;

endpackage

`default_nettype wire

//--- tw_credit_gate.sv
`default_nettype none

`include "tw_defs.svh"

module tw_credit_gate (
   input  wire logic                 CLK,
   input  wire logic                 rst_n,
   input  wire ntt_ctrl_pkg::stage_e stage,
   input  wire logic                 credit_return,
   output logic                      issue
);
   import ntt_ctrl_pkg::*;

   logic [`TW_CREDIT_W-1:0] credit_cnt;
   logic                    credit_full;

   assign credit_full = (credit_cnt == `TW_CREDIT_W'(`TW_CREDITS));
   assign issue       = (credit_cnt != '0) && (stage != STAGE_IDLE);

   always_ff @(posedge CLK or negedge rst_n) begin
      if (!rst_n) begin
         credit_cnt <= `TW_CREDIT_W'(`TW_CREDITS);   // Consumer starts empty
      end else if (issue && !credit_return) begin
         credit_cnt <= credit_cnt - 1'b1;
      end else if (!issue && credit_return && !credit_full) begin
         credit_cnt <= credit_cnt + 1'b1;
      end
      // Issue and return together leave the count unchanged
   end

endmodule

`default_nettype wire

//--- tw_addr_seq.sv
`default_nettype none

`include "tw_defs.svh"

module tw_addr_seq (
   input  wire logic                 CLK,
   input  wire logic                 rst_n,
   input  wire ntt_ctrl_pkg::stage_e stage,
   input  wire ntt_ctrl_pkg::op_e    op,
   input  wire logic                 issue,
   output logic [`TW_IDX_W-1:0]      rd_idx
);
   import ntt_ctrl_pkg::*;

   localparam int ENT_W = $clog2(`TW_ENTRIES);
   localparam int REP_W = $clog2(`TW_REPEAT_1);
   localparam int GRP_W = $clog2(`TW_GROUPS_1);

   logic [ENT_W-1:0] entry;
   logic [ENT_W-1:0] ent_cur;
   logic [REP_W-1:0] rep;
   logic [REP_W-1:0] rep_cur;
   logic [GRP_W-1:0] grp;
   stage_e           last_stage;
   logic             stage_chg;
   logic             advance;
   logic             ent_wrap;
   logic             rep_wrap;

   // A new stage starts from entry 0 in the same cycle it appears
   assign stage_chg = (stage != last_stage);
   assign ent_cur   = stage_chg ? '0 : entry;
   assign rep_cur   = stage_chg ? '0 : rep;

   assign advance  = (op == OP_NTT) || (op == OP_INTT);
   assign ent_wrap = (ent_cur == ENT_W'(`TW_ENTRIES - 1));
   assign rep_wrap = (rep_cur == REP_W'(`TW_REPEAT_1 - 1));

   always_comb begin
      case (stage)
         STAGE_1: rd_idx = `TW_IDX_W'({grp, ent_cur});   // group * entries + entry
         STAGE_2: rd_idx = `TW_IDX_W'(ent_cur);
         default: rd_idx = '0;
      endcase
   end

   always_ff @(posedge CLK or negedge rst_n) begin
      if (!rst_n) begin
         entry      <= '0;
         rep        <= '0;
         grp        <= '0;
         last_stage <= STAGE_IDLE;
      end else begin
         last_stage <= stage;
         entry      <= ent_cur;
         rep        <= rep_cur;
         if (issue) begin
            if (!advance) begin
               entry <= '0;   // Rewind outside butterfly ops
            end else if (ent_wrap) begin
               entry <= '0;
               if (stage == STAGE_1) begin
                  rep <= rep_wrap ? '0 : rep_cur + 1'b1;
                  if (rep_wrap) begin
                     grp <= (grp == GRP_W'(`TW_GROUPS_1 - 1)) ? '0 : grp + 1'b1;
                  end
               end
            end else begin
               entry <= ent_cur + 1'b1;
            end
         end
      end
   end

endmodule

`default_nettype wire

//--- tw_rom.sv
`default_nettype none

`include "tw_defs.svh"

module tw_rom (
   input  wire logic                 CLK,
   input  wire logic                 rst_n,
   input  wire ntt_ctrl_pkg::stage_e stage,
   input  wire logic                 issue,
   input  wire logic [`TW_IDX_W-1:0] rd_idx,
   output tw_data_pkg::tw_beat_t     beat
);
   import ntt_ctrl_pkg::*;
   import tw_data_pkg::*;

   localparam int S1_DEPTH = `TW_GROUPS_1 * `TW_ENTRIES;
   localparam int S2_IDX_W = $clog2(`TW_ENTRIES);

   // Stage 1, four groups of four
   localparam tw_word_t S1_TBL [S1_DEPTH] = '{
      128'h0000000000000001_0000000000000001,
      128'h007fffffffffff80_3babf8a70b9016d7,
      128'h7fffffff00000001_fffffffdffff0002,
      128'h00000040003fffc0_fbc8a1ec30654b2b,
      128'hd1df70583aa377bd_1ee20087ae155450,
      128'h1ae5253581bde075_2ec5857427dec65f,
      128'h62ae44218641740b_5162deb878a773ba,
      128'hbf210fc4ce5182d6_52ace2fc90457a99,
      128'h48bb429405cd1ea3_5ce12fcfabc79d87,
      128'h3de19c67cf496a74_8024d1d331c08932,
      128'h7d1970ae2744309c_246859d06b222a38,
      128'h185b4ac60695836e_fc6bc4e828b3db2b,
      128'h969e9096afde4510_6a7c9217f0ce3407,
      128'h840fa37ec53a39e1_d2abf21029ace519,
      128'ha810dd77a33e6ad4_7d1970ae2744309c,
      128'h1d62e30fa4a4eeb0_e4421e8e1740a9d6
   };

   localparam tw_word_t S2_TBL [`TW_ENTRIES] = '{
      128'h0000000000000001_0000000000000001,
      128'hfffffffec0000001_0001fffffffe0000,
      128'h1000000000000000_fffffffb00000005,
      128'hfbffffff04000001_0008000000000000
   };

   // Stage constant, the same for stage 1 and stage 2
   localparam tw_word_t STAGE_CONST = 128'hfffffffec0000001_0001fffffffe0000;

   tw_word_t word_sel;
   tw_word_t word_q;
   logic     valid_q;

   always_comb begin
      case (stage)
         STAGE_2: word_sel = S2_TBL[rd_idx[S2_IDX_W-1:0]];
         default: word_sel = S1_TBL[rd_idx];   // Idle never issues
      endcase
   end

   always_ff @(posedge CLK or negedge rst_n) begin
      if (!rst_n) begin
         valid_q <= 1'b0;
      end else begin
         valid_q <= issue;
      end
   end

   // Payload holds between issues
   always_ff @(posedge CLK) begin
      if (issue) begin
         word_q <= word_sel;
      end
   end

   assign beat = '{valid: valid_q, word: word_q, const_word: STAGE_CONST};

endmodule

`default_nettype wire

//--- tw_top.sv
`default_nettype none

`include "tw_defs.svh"

module tw_top (
   input  wire logic                 CLK,
   input  wire logic                 rst_n,
   input  wire ntt_ctrl_pkg::stage_e stage,
   input  wire ntt_ctrl_pkg::op_e    op,
   input  wire logic                 credit_return,
   output tw_data_pkg::tw_beat_t     beat
);

   logic                 issue;
   logic [`TW_IDX_W-1:0] rd_idx;

   tw_credit_gate credit_gate_i (
      .CLK           (CLK),
      .rst_n         (rst_n),
      .stage         (stage),
      .credit_return (credit_return),
      .issue         (issue)
   );

   tw_addr_seq addr_seq_i (
      .CLK    (CLK),
      .rst_n  (rst_n),
      .stage  (stage),
      .op     (op),
      .issue  (issue),
      .rd_idx (rd_idx)
   );

   tw_rom rom_i (
      .CLK    (CLK),
      .rst_n  (rst_n),
      .stage  (stage),
      .issue  (issue),
      .rd_idx (rd_idx),
      .beat   (beat)
   );

endmodule

`default_nettype wire

//--- tw_tb.sv
`default_nettype none

`include "tw_defs.svh"

module tw_tb;
   import ntt_ctrl_pkg::*;
   import tw_data_pkg::*;

   logic     CLK;
   logic     rst_n;
   stage_e   stage;
   op_e      op;
   logic     credit_return;
   tw_beat_t beat;

   tw_word_t tbl [0:20];   // 0..15 stage 1, 16..19 stage 2, 20 constant
   int       seg_test[$];
   int       seg_stage[$];
   int       seg_op[$];
   int       seg_cr[$];
   int       seg_len[$];
   int       limit = 1000;
   int       cycles = 0;
   bit       trace_ok;

   // Reference state of the twiddle source
   int       credits = `TW_CREDITS;
   int       entry = 0;
   int       rep = 0;
   int       grp = 0;
   stage_e   last_stage = STAGE_IDLE;
   logic     exp_valid = 1'b0;
   logic     have_word = 1'b0;
   tw_word_t exp_word;
   tw_word_t exp_const;

   int       cur_test = 0;
   int       test_err = 0;
   int       n_tests = 0;
   int       n_failed = 0;
   int       n_checks = 0;
   int       n_errors = 0;

   tw_top dut_i (
      .CLK           (CLK),
      .rst_n         (rst_n),
      .stage         (stage),
      .op            (op),
      .credit_return (credit_return),
      .beat          (beat)
   );

   initial begin
      CLK = 1'b0;
      forever #50 CLK = ~CLK;
   end

   initial begin
      forever begin
         @(posedge CLK);
         cycles++;
         if (cycles > limit) begin
            $display("ERROR: run exceeded %0d cycles without finishing", limit);
            $display("TESTS FAILED");
            $finish;
         end
      end
   end

   task automatic load_trace(output bit ok);
      int     fd;
      int     slot;
      int     a;
      int     b;
      int     c;
      int     d;
      int     e;
      int     total;
      string  line;
      logic [127:0] w;
      total = 0;
      ok = 1'b0;
      fd = $fopen("tw_trace.txt", "r");
      if (fd == 0) begin
         $display("ERROR: cannot open tw_trace.txt");
      end else begin
         while ($fgets(line, fd) != 0) begin
            if (line.len() == 0 || line.getc(0) == "#" || line.getc(0) == "\n") begin
               continue;
            end
            if (line.getc(0) == "w") begin
               if ($sscanf(line, "w %d %h", slot, w) == 2) tbl[slot] = w;
            end else if (line.getc(0) == "c") begin
               if ($sscanf(line, "c %d %d %d %d %d", a, b, c, d, e) == 5) begin
                  seg_test.push_back(a);
                  seg_stage.push_back(b);
                  seg_op.push_back(c);
                  seg_cr.push_back(d);
                  seg_len.push_back(e);
                  total += e;
               end
            end
         end
         $fclose(fd);
         limit = total + 5 + 50;   // Reset plus trace plus margin
         ok = 1'b1;
      end
   endtask

   task automatic report_test();
      n_tests++;
      if (test_err == 0) begin
         $display("test %0d: ok", cur_test);
      end else begin
         n_failed++;
         $display("test %0d: failed with %0d errors", cur_test, test_err);
      end
      test_err = 0;
   endtask

   task automatic check_beat();
      n_checks++;
      assert (beat.valid === exp_valid) else begin
         $display("MISMATCH test %0d beat.valid: got %h, expected %h",
                  cur_test, beat.valid, exp_valid);
         test_err++;
         n_errors++;
      end
      if (have_word) begin
         assert (beat.word === exp_word) else begin
            $display("MISMATCH test %0d beat.word: got %h, expected %h",
                     cur_test, beat.word, exp_word);
            test_err++;
            n_errors++;
         end
         assert (beat.const_word === exp_const) else begin
            $display("MISMATCH test %0d beat.const_word: got %h, expected %h",
                     cur_test, beat.const_word, exp_const);
            test_err++;
            n_errors++;
         end
      end
   endtask

   // One cycle of the sequence and credit rules
   task automatic step_model();
      logic issue;
      logic adv;
      int   ent;
      int   rp;
      issue = (credits != 0) && (stage != STAGE_IDLE);
      adv   = (op == OP_NTT) || (op == OP_INTT);
      ent   = (stage != last_stage) ? 0 : entry;
      rp    = (stage != last_stage) ? 0 : rep;
      exp_valid = issue;
      if (issue) begin
         have_word = 1'b1;
         exp_word  = (stage == STAGE_2) ? tbl[16 + ent] : tbl[grp * 4 + ent];
         exp_const = tbl[20];
      end
      last_stage = stage;
      entry = ent;
      rep   = rp;
      if (issue) begin
         if (!adv) begin
            entry = 0;
         end else if (ent == `TW_ENTRIES - 1) begin
            entry = 0;
            if (stage == STAGE_1) begin
               if (rp == `TW_REPEAT_1 - 1) begin
                  rep = 0;
                  grp = (grp + 1) % `TW_GROUPS_1;
               end else begin
                  rep = rp + 1;
               end
            end
         end else begin
            entry = ent + 1;
         end
      end
      if (issue && !credit_return) begin
         credits--;
      end else if (!issue && credit_return && credits < `TW_CREDITS) begin
         credits++;
      end
   endtask

   initial begin
      rst_n         = 1'b0;
      stage         = STAGE_IDLE;
      op            = OP_NONE;
      credit_return = 1'b0;
      load_trace(trace_ok);
      if (!trace_ok) begin
         $display("TESTS FAILED");
         $finish;
      end else begin
         repeat (5) @(posedge CLK);
         #10 rst_n = 1'b1;
         foreach (seg_test[s]) begin
            if (seg_test[s] != cur_test) begin
               if (cur_test != 0) report_test();
               cur_test = seg_test[s];
            end
            for (int k = 0; k < seg_len[s]; k++) begin
               @(posedge CLK);
               #10;
               stage         = stage_e'(seg_stage[s]);
               op            = op_e'(seg_op[s]);
               credit_return = seg_cr[s][0];
               #80;
               check_beat();   // Result of the previous cycle's issue
               step_model();
            end
         end
         report_test();
         $display("tests %0d, failed %0d, checks %0d, errors %0d",
                  n_tests, n_failed, n_checks, n_errors);
         if (n_errors == 0 && n_failed == 0) begin
            $display("TESTS PASSED");
         end else begin
            $display("TESTS FAILED");
         end
         $finish;
      end
   end

endmodule

`default_nettype wire

//--- tw_trace.txt
# w <slot> <word hex>: slots 0-15 stage 1 table, 16-19 stage 2 table, 20 stage constant
# c <test> <stage> <op> <credit_return> <cycles>: stage 0 idle 1 s1 2 s2, op 0 none 4 ntt 6 intt
w 0 00000000000000010000000000000001
w 1 007fffffffffff803babf8a70b9016d7
w 2 7fffffff00000001fffffffdffff0002
w 3 00000040003fffc0fbc8a1ec30654b2b
w 4 d1df70583aa377bd1ee20087ae155450
w 5 1ae5253581bde0752ec5857427dec65f
w 6 62ae44218641740b5162deb878a773ba
w 7 bf210fc4ce5182d652ace2fc90457a99
w 8 48bb429405cd1ea35ce12fcfabc79d87
w 9 3de19c67cf496a748024d1d331c08932
w 10 7d1970ae2744309c246859d06b222a38
w 11 185b4ac60695836efc6bc4e828b3db2b
w 12 969e9096afde45106a7c9217f0ce3407
w 13 840fa37ec53a39e1d2abf21029ace519
w 14 a810dd77a33e6ad47d1970ae2744309c
w 15 1d62e30fa4a4eeb0e4421e8e1740a9d6
w 16 00000000000000010000000000000001
w 17 fffffffec00000010001fffffffe0000
w 18 1000000000000000fffffffb00000005
w 19 fbffffff040000010008000000000000
w 20 fffffffec00000010001fffffffe0000
c 1 0 0 0 2
c 1 2 4 0 8
c 2 2 4 1 10
c 3 1 6 1 258
c 4 1 4 1 2
c 4 1 0 1 3
c 4 1 4 1 3
c 5 1 4 0 6
c 5 1 4 1 6
c 6 2 4 1 3
c 6 1 4 1 3
c 6 0 0 0 3

//--- compile.f
+incdir+.
ntt_ctrl_pkg.sv
tw_data_pkg.sv
tw_credit_gate.sv
tw_addr_seq.sv
tw_rom.sv
tw_top.sv
tw_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the twiddle source testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tw_tb -f compile.f -o tw_sim
if [ $? -ne 0 ]; then
   echo "build failed"
   exit 1
fi

./obj_dir/tw_sim > sim.log 2>&1
status=$?
cat sim.log

if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "TESTS FAILED" sim.log; then
   exit 1
fi

if ! grep -q "TESTS PASSED" sim.log; then
   echo "no result line in sim.log"
   exit 1
fi

exit 0
